//--- src/rvCore_macros.svh
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

// one-word datapath width in bits
`define DATA_WIDTH     32

// architectural integer registers x0..x31
`define REG_COUNT      32
`define REG_ADDR_WIDTH 5

`endif

//--- src/rvDecodePkg.sv
`include "rvCore_macros.svh"

package rvDecodePkg;

    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeT;

    typedef enum logic [1:0] {
        aluOpAdd    = 2'b00,
        aluOpBranch = 2'b01,
        aluOpFunct  = 2'b10,
        aluOpNone   = 2'b11
    } aluOpT;

    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSub  = 4'b0001,
        aluSll  = 4'b0010,
        aluSlt  = 4'b0011,
        aluSltu = 4'b0100,
        aluXor  = 4'b0101,
        aluSrl  = 4'b0110,
        aluSra  = 4'b0111,
        aluOr   = 4'b1000,
        aluAnd  = 4'b1001
    } aluCtrlT;

    typedef enum logic [2:0] {
        immI    = 3'b000,
        immS    = 3'b001,
        immB    = 3'b010,
        immU    = 3'b011,
        immJ    = 3'b100,
        immNone = 3'b111
    } immSrcT;

    typedef enum logic [1:0] {
        resAlu  = 2'b00,
        resMem  = 2'b01,
        resPc4  = 2'b10,
        resNone = 2'b11
    } resultSrcT;

    typedef enum logic [2:0] {
        memNone  = 3'b000,
        memWord  = 3'b001,
        memHalf  = 3'b010,
        memByte  = 3'b011,
        memHalfU = 3'b100,
        memByteU = 3'b101
    } memModeT;

    typedef enum logic [1:0] {
        srcReg  = 2'b00,
        srcZero = 2'b01,  // lui
        srcPc   = 2'b10   // auipc
    } srcASelT;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        logic      memWrite;
        logic      memRead;
        logic      jump;
        logic      branch;
        logic      jalr;
        aluCtrlT   aluCtrl;
        logic      aluSrcB;   // 1 selects the immediate
        srcASelT   srcASel;
        immSrcT    immSrc;
        memModeT   memMode;
        logic [2:0] funct3;   // branch condition
    } decodeCtrlT;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0]     rd1;
        logic [`DATA_WIDTH-1:0]     rd2;
        logic [`DATA_WIDTH-1:0]     pc;
        logic [`DATA_WIDTH-1:0]     pcPlus4;
        logic [`DATA_WIDTH-1:0]     immExt;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rd;
    } decodeDataT;

    typedef struct packed {
        logic                       regWrite;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     result;
    } writeBackT;

endpackage

//--- src/aluDecoder.sv
`timescale 1ns/100ps

module aluDecoder
    import rvDecodePkg::*;
(
    input  aluOpT      aluOp,
    input  logic       opBit5,
    input  logic [2:0] funct3,
    input  logic       funct7Bit5,
    output aluCtrlT    aluCtrl
);

    always_comb begin
        case (aluOp)
            aluOpAdd: aluCtrl = aluAdd;  // address calc for loads/stores
            aluOpBranch: begin
                case (funct3[2:1])
                    2'b10:   aluCtrl = aluSlt;   // blt/bge
                    2'b11:   aluCtrl = aluSltu;  // bltu/bgeu
                    default: aluCtrl = aluSub;   // beq/bne
                endcase
            end
            aluOpFunct: begin
                case (funct3)
                    3'b000: begin
                        // sub needs R-type and funct7 bit 5
                        if (opBit5 && funct7Bit5) begin
                            aluCtrl = aluSub;
                        end else begin
                            aluCtrl = aluAdd;
                        end
                    end
                    3'b001:  aluCtrl = aluSll;
                    3'b010:  aluCtrl = aluSlt;
                    3'b011:  aluCtrl = aluSltu;
                    3'b100:  aluCtrl = aluXor;
                    3'b101:  aluCtrl = funct7Bit5 ? aluSra : aluSrl;  // srai too
                    3'b110:  aluCtrl = aluOr;
                    default: aluCtrl = aluAnd;
                endcase
            end
            default: aluCtrl = aluAdd;
        endcase
    end

endmodule

//--- src/controlUnit.sv
`timescale 1ns/100ps
`include "rvCore_macros.svh"

module controlUnit
    import rvDecodePkg::*;
(
    input  logic [`DATA_WIDTH-1:0] instrD,
    output decodeCtrlT             ctrlD
);

    opcodeT     opcode;
    logic [2:0] funct3;
    aluOpT      aluOp;
    aluCtrlT    aluCtrl;
    logic       isLoad;
    logic       isStore;

    assign opcode = opcodeT'(instrD[6:0]);
    assign funct3 = instrD[14:12];

    always_comb begin
        // invalid row unless the opcode matches
        ctrlD           = '0;
        ctrlD.resultSrc = resNone;
        ctrlD.immSrc    = immNone;
        ctrlD.aluSrcB   = 1'b1;
        ctrlD.srcASel   = srcReg;
        ctrlD.aluCtrl   = aluCtrl;
        ctrlD.funct3    = funct3;
        aluOp           = aluOpNone;
        isLoad          = 1'b0;
        isStore         = 1'b0;

        case (opcode)
            opReg: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = resAlu;
                ctrlD.aluSrcB   = 1'b0;
                aluOp           = aluOpFunct;
            end
            opImm: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = resAlu;
                ctrlD.immSrc    = immI;
                aluOp           = aluOpFunct;
            end
            opLoad: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = resMem;
                ctrlD.immSrc    = immI;
                ctrlD.memRead   = 1'b1;
                aluOp           = aluOpAdd;
                isLoad          = 1'b1;
            end
            opStore: begin
                ctrlD.resultSrc = resAlu;
                ctrlD.immSrc    = immS;
                ctrlD.memWrite  = 1'b1;
                aluOp           = aluOpAdd;
                isStore         = 1'b1;
            end
            opBranch: begin
                ctrlD.resultSrc = resAlu;
                ctrlD.immSrc    = immB;
                ctrlD.aluSrcB   = 1'b0;
                ctrlD.branch    = 1'b1;
                aluOp           = aluOpBranch;
            end
            opLui, opAuipc: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = resAlu;
                ctrlD.immSrc    = immU;
                ctrlD.srcASel   = (opcode == opLui) ? srcZero : srcPc;
                aluOp           = aluOpAdd;
            end
            opJal: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = resPc4;  // link address
                ctrlD.immSrc    = immJ;
                ctrlD.aluSrcB   = 1'b0;
                ctrlD.jump      = 1'b1;
            end
            opJalr: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = resPc4;
                ctrlD.immSrc    = immI;  // offset is I-format
                ctrlD.aluSrcB   = 1'b0;
                ctrlD.jump      = 1'b1;
                ctrlD.jalr      = 1'b1;
                aluOp           = aluOpAdd;
            end
            default: ;
        endcase

        ctrlD.memMode = memNone;
        if (isLoad || isStore) begin
            case (funct3)
                3'b000:  ctrlD.memMode = memByte;
                3'b001:  ctrlD.memMode = memHalf;
                3'b010:  ctrlD.memMode = memWord;
                3'b100:  ctrlD.memMode = isLoad ? memByteU : memNone;  // lbu only
                3'b101:  ctrlD.memMode = isLoad ? memHalfU : memNone;  // lhu only
                default: ctrlD.memMode = memNone;
            endcase
        end
    end

    aluDecoder aluDec (
        .aluOp     (aluOp),
        .opBit5    (instrD[5]),
        .funct3    (funct3),
        .funct7Bit5(instrD[30]),
        .aluCtrl   (aluCtrl)
    );

endmodule

//--- src/immExtend.sv
`timescale 1ns/100ps
`include "rvCore_macros.svh"

module immExtend
    import rvDecodePkg::*;
(
    input  logic [`DATA_WIDTH-1:0] instrD,
    input  immSrcT                 immSrc,
    output logic [`DATA_WIDTH-1:0] immExt
);

    logic signBit;

    assign signBit = instrD[31];

    always_comb begin
        case (immSrc)
            immI: immExt = {{20{signBit}}, instrD[31:20]};
            immS: immExt = {{20{signBit}}, instrD[31:25], instrD[11:7]};
            immB: begin
                immExt = {{20{signBit}}, instrD[7], instrD[30:25],
                          instrD[11:8], 1'b0};  // halfword aligned
            end
            immU: immExt = {instrD[31:12], 12'b0};
            immJ: begin
                immExt = {{12{signBit}}, instrD[19:12], instrD[20],
                          instrD[30:21], 1'b0};
            end
            default: immExt = '0;  // no immediate
        endcase
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/100ps
`include "rvCore_macros.svh"

module regFile
    import rvDecodePkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    input  writeBackT                  writeBack,
    output logic [`DATA_WIDTH-1:0]     rd1,
    output logic [`DATA_WIDTH-1:0]     rd2
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic                   wrEn;

    assign wrEn = writeBack.regWrite && (writeBack.rd != '0);  // x0 never written

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[writeBack.rd] <= writeBack.result;
        end
    end

    // same-cycle write is visible to the reader
    always_comb begin
        if (rs1 == '0) begin
            rd1 = '0;
        end else if (wrEn && (writeBack.rd == rs1)) begin
            rd1 = writeBack.result;
        end else begin
            rd1 = regs[rs1];
        end
        if (rs2 == '0) begin
            rd2 = '0;
        end else if (wrEn && (writeBack.rd == rs2)) begin
            rd2 = writeBack.result;
        end else begin
            rd2 = regs[rs2];
        end
    end

endmodule

//--- src/decodeStage.sv
`timescale 1ns/100ps
`include "rvCore_macros.svh"

module decodeStage
    import rvDecodePkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`DATA_WIDTH-1:0] instrD,
    input  logic [`DATA_WIDTH-1:0] pcD,
    input  logic [`DATA_WIDTH-1:0] pcPlus4D,
    input  writeBackT              writeBack,
    input  logic                   stallE,
    input  logic                   flushE,
    output decodeCtrlT             ctrlE,
    output decodeDataT             dataE
);

    // nothing architectural happens for a bubble
    localparam decodeCtrlT ctrlBubble = '{
        regWrite:  1'b0,
        resultSrc: resNone,
        memWrite:  1'b0,
        memRead:   1'b0,
        jump:      1'b0,
        branch:    1'b0,
        jalr:      1'b0,
        aluCtrl:   aluAdd,
        aluSrcB:   1'b0,
        srcASel:   srcReg,
        immSrc:    immNone,
        memMode:   memNone,
        funct3:    3'b000
    };

    decodeCtrlT             ctrlD;
    decodeDataT             dataD;
    logic [`DATA_WIDTH-1:0] immExtD;
    logic [`DATA_WIDTH-1:0] rd1D;
    logic [`DATA_WIDTH-1:0] rd2D;

    controlUnit ctrlUnit (
        .instrD(instrD),
        .ctrlD (ctrlD)
    );

    immExtend immExt (
        .instrD(instrD),
        .immSrc(ctrlD.immSrc),
        .immExt(immExtD)
    );

    regFile rf (
        .clk      (clk),
        .rstN     (rstN),
        .rs1      (instrD[19:15]),
        .rs2      (instrD[24:20]),
        .writeBack(writeBack),
        .rd1      (rd1D),
        .rd2      (rd2D)
    );

    assign dataD = '{
        rd1:     rd1D,
        rd2:     rd2D,
        pc:      pcD,
        pcPlus4: pcPlus4D,
        immExt:  immExtD,
        rs1:     instrD[19:15],  // kept for forwarding in execute
        rs2:     instrD[24:20],
        rd:      instrD[11:7]
    };

    // decode/execute register where stall beats flush
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlE <= ctrlBubble;
            dataE <= '0;
        end else if (!stallE) begin
            if (flushE) begin
                ctrlE <= ctrlBubble;
                dataE <= '0;
            end else begin
                ctrlE <= ctrlD;
                dataE <= dataD;
            end
        end
    end

endmodule

//--- verif/decodeStage_tb.sv
`timescale 1ns/100ps
`include "rvCore_macros.svh"

module decodeStage_tb
    import rvDecodePkg::*;
();

    typedef struct {
        string       name;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        stall;
        logic        flush;
        writeBackT   wb;
        decodeCtrlT  expCtrl;
        decodeDataT  expData;
    } caseT;

    logic                   clk;
    logic                   rstN;
    logic [`DATA_WIDTH-1:0] instrD;
    logic [`DATA_WIDTH-1:0] pcD;
    logic [`DATA_WIDTH-1:0] pcPlus4D;
    writeBackT              writeBack;
    logic                   stallE;
    logic                   flushE;
    decodeCtrlT             ctrlE;
    decodeDataT             dataE;

    caseT                   cases[$];
    logic [`DATA_WIDTH-1:0] model [`REG_COUNT];  // expected register contents
    decodeCtrlT             bubbleCtrl;
    integer                 seed;
    integer                 errors;
    integer                 checks;

    decodeStage uut (
        .clk      (clk),
        .rstN     (rstN),
        .instrD   (instrD),
        .pcD      (pcD),
        .pcPlus4D (pcPlus4D),
        .writeBack(writeBack),
        .stallE   (stallE),
        .flushE   (flushE),
        .ctrlE    (ctrlE),
        .dataE    (dataE)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

    // flags are {regWrite, memWrite, memRead, jump, branch, jalr}
    function automatic decodeCtrlT mkCtrl(logic [5:0] flags, resultSrcT res, aluCtrlT alu,
                                          logic srcB, srcASelT srcA, immSrcT imm,
                                          memModeT mem);
        decodeCtrlT c;
        c = '0;
        {c.regWrite, c.memWrite, c.memRead, c.jump, c.branch, c.jalr} = flags;
        c.resultSrc = res;
        c.aluCtrl   = alu;
        c.aluSrcB   = srcB;
        c.srcASel   = srcA;
        c.immSrc    = imm;
        c.memMode   = mem;
        return c;
    endfunction

    function automatic logic [31:0] rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] bType(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] uType(logic [19:0] imm, logic [4:0] rd, opcodeT op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    task automatic addEntry(input string name, input logic [31:0] instr, input logic stall,
                            input logic flush, input logic wbEn, input logic [4:0] wbRd,
                            input decodeCtrlT ctrl, input logic [31:0] imm);
        caseT c;
        c.name  = name;
        c.instr = instr;
        c.pc    = 32'h0000_1000 + 32'(cases.size() * 4);
        c.stall = stall;
        c.flush = flush;
        c.wb    = '0;
        if (wbEn) begin
            c.wb.regWrite = 1'b1;
            c.wb.rd       = wbRd;
            c.wb.result   = $random(seed);
            if (wbRd != 5'd0) model[wbRd] = c.wb.result;  // same-edge write is bypassed
        end
        if (stall) begin
            c.expCtrl = cases[$].expCtrl;  // register holds
            c.expData = cases[$].expData;
        end else if (flush) begin
            c.expCtrl = bubbleCtrl;
            c.expData = '0;
        end else begin
            c.expCtrl         = ctrl;
            c.expCtrl.funct3  = instr[14:12];
            c.expData.rd1     = model[instr[19:15]];
            c.expData.rd2     = model[instr[24:20]];
            c.expData.pc      = c.pc;
            c.expData.pcPlus4 = c.pc + 32'd4;
            c.expData.immExt  = imm;
            c.expData.rs1     = instr[19:15];
            c.expData.rs2     = instr[24:20];
            c.expData.rd      = instr[11:7];
        end
        cases.push_back(c);
    endtask

    task automatic addDecode(input string name, input logic [31:0] instr,
                             input decodeCtrlT ctrl, input logic [31:0] imm);
        addEntry(name, instr, 1'b0, 1'b0, 1'b0, 5'd0, ctrl, imm);
    endtask

    task automatic buildCases();
        decodeCtrlT invalidCtrl;
        decodeCtrlT addCtrl;
        bubbleCtrl  = mkCtrl(6'b000000, resNone, aluAdd, 1'b0, srcReg, immNone, memNone);
        invalidCtrl = mkCtrl(6'b000000, resNone, aluAdd, 1'b1, srcReg, immNone, memNone);
        addCtrl     = mkCtrl(6'b100000, resAlu, aluAdd, 1'b0, srcReg, immNone, memNone);
        for (int r = 0; r < `REG_COUNT; r++) model[r] = '0;
        for (int r = 1; r <= 6; r++) begin
            addEntry($sformatf("write x%0d", r), 32'h0, 1'b0, 1'b0, 1'b1, 5'(r),
                invalidCtrl, 32'h0);
        end
        addEntry("write x0", rType(7'h00, 5'd1, 5'd0, 3'b000, 5'd15), 1'b0, 1'b0,
            1'b1, 5'd0, addCtrl, 32'h0);
        addDecode("add", rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), addCtrl, 32'h0);
        addDecode("sub", rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd4),
            mkCtrl(6'b100000, resAlu, aluSub, 1'b0, srcReg, immNone, memNone), 32'h0);
        addDecode("sra", rType(7'h20, 5'd2, 5'd1, 3'b101, 5'd5),
            mkCtrl(6'b100000, resAlu, aluSra, 1'b0, srcReg, immNone, memNone), 32'h0);
        addDecode("addi", iType(12'hffb, 5'd1, 3'b000, 5'd6, opImm),  // bit 30 set yet still add
            mkCtrl(6'b100000, resAlu, aluAdd, 1'b1, srcReg, immI, memNone), 32'hffff_fffb);
        addDecode("srai", iType(12'h403, 5'd2, 3'b101, 5'd7, opImm),
            mkCtrl(6'b100000, resAlu, aluSra, 1'b1, srcReg, immI, memNone), 32'h0000_0403);
        addDecode("lw", iType(12'h010, 5'd1, 3'b010, 5'd8, opLoad),
            mkCtrl(6'b101000, resMem, aluAdd, 1'b1, srcReg, immI, memWord), 32'h0000_0010);
        addDecode("lbu", iType(12'hfff, 5'd2, 3'b100, 5'd9, opLoad),
            mkCtrl(6'b101000, resMem, aluAdd, 1'b1, srcReg, immI, memByteU), 32'hffff_ffff);
        addDecode("lhu", iType(12'h002, 5'd3, 3'b101, 5'd10, opLoad),
            mkCtrl(6'b101000, resMem, aluAdd, 1'b1, srcReg, immI, memHalfU), 32'h0000_0002);
        addDecode("sb", sType(12'h007, 5'd2, 5'd1, 3'b000),
            mkCtrl(6'b010000, resAlu, aluAdd, 1'b1, srcReg, immS, memByte), 32'h0000_0007);
        addDecode("sh", sType(12'hff8, 5'd3, 5'd4, 3'b001),
            mkCtrl(6'b010000, resAlu, aluAdd, 1'b1, srcReg, immS, memHalf), 32'hffff_fff8);
        addDecode("beq", bType(13'h0010, 5'd2, 5'd1, 3'b000),
            mkCtrl(6'b000010, resAlu, aluSub, 1'b0, srcReg, immB, memNone), 32'h0000_0010);
        addDecode("bltu", bType(13'h1ffc, 5'd4, 5'd3, 3'b110),
            mkCtrl(6'b000010, resAlu, aluSltu, 1'b0, srcReg, immB, memNone), 32'hffff_fffc);
        addDecode("lui", uType(20'h12345, 5'd11, opLui),
            mkCtrl(6'b100000, resAlu, aluAdd, 1'b1, srcZero, immU, memNone), 32'h1234_5000);
        addDecode("auipc", uType(20'h80000, 5'd12, opAuipc),
            mkCtrl(6'b100000, resAlu, aluAdd, 1'b1, srcPc, immU, memNone), 32'h8000_0000);
        addDecode("jal", jType(21'h1f_f800, 5'd1),
            mkCtrl(6'b100100, resPc4, aluAdd, 1'b0, srcReg, immJ, memNone), 32'hffff_f800);
        addDecode("jalr", iType(12'h004, 5'd5, 3'b000, 5'd1, opJalr),
            mkCtrl(6'b100101, resPc4, aluAdd, 1'b0, srcReg, immI, memNone), 32'h0000_0004);
        addDecode("invalid", 32'hffff_ffff, invalidCtrl, 32'h0);
        addEntry("bypass x2", rType(7'h00, 5'd1, 5'd2, 3'b000, 5'd13), 1'b0, 1'b0,
            1'b1, 5'd2, addCtrl, 32'h0);
        addDecode("stall base", rType(7'h00, 5'd4, 5'd3, 3'b000, 5'd16), addCtrl, 32'h0);
        addEntry("stall hold", rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd17), 1'b1, 1'b0,
            1'b0, 5'd0, invalidCtrl, 32'h0);
        addEntry("flush", iType(12'h010, 5'd1, 3'b010, 5'd8, opLoad), 1'b0, 1'b1,
            1'b0, 5'd0, invalidCtrl, 32'h0);
        addDecode("after flush", rType(7'h00, 5'd6, 5'd5, 3'b000, 5'd18), addCtrl, 32'h0);
        addEntry("stall over flush", 32'hffff_ffff, 1'b1, 1'b1, 1'b0, 5'd0, invalidCtrl, 32'h0);
    endtask

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expVal, input logic [31:0] actVal);
        checks++;
        if (actVal !== expVal) begin
            errors++;
            $display("** Error: %s %s expected %h actual %h", testName, field, expVal, actVal);
        end
    endtask

    task automatic checkOutputs(input string name, input decodeCtrlT ec, input decodeDataT ed);
        checkValue(name, "regWrite", 32'(ec.regWrite), 32'(ctrlE.regWrite));
        checkValue(name, "resultSrc", 32'(ec.resultSrc), 32'(ctrlE.resultSrc));
        checkValue(name, "memWrite", 32'(ec.memWrite), 32'(ctrlE.memWrite));
        checkValue(name, "memRead", 32'(ec.memRead), 32'(ctrlE.memRead));
        checkValue(name, "jump", 32'(ec.jump), 32'(ctrlE.jump));
        checkValue(name, "branch", 32'(ec.branch), 32'(ctrlE.branch));
        checkValue(name, "jalr", 32'(ec.jalr), 32'(ctrlE.jalr));
        checkValue(name, "aluCtrl", 32'(ec.aluCtrl), 32'(ctrlE.aluCtrl));
        checkValue(name, "aluSrcB", 32'(ec.aluSrcB), 32'(ctrlE.aluSrcB));
        checkValue(name, "srcASel", 32'(ec.srcASel), 32'(ctrlE.srcASel));
        checkValue(name, "immSrc", 32'(ec.immSrc), 32'(ctrlE.immSrc));
        checkValue(name, "memMode", 32'(ec.memMode), 32'(ctrlE.memMode));
        checkValue(name, "funct3", 32'(ec.funct3), 32'(ctrlE.funct3));
        checkValue(name, "rd1", ed.rd1, dataE.rd1);
        checkValue(name, "rd2", ed.rd2, dataE.rd2);
        checkValue(name, "pc", ed.pc, dataE.pc);
        checkValue(name, "pcPlus4", ed.pcPlus4, dataE.pcPlus4);
        checkValue(name, "immExt", ed.immExt, dataE.immExt);
        checkValue(name, "rs1", 32'(ed.rs1), 32'(dataE.rs1));
        checkValue(name, "rs2", 32'(ed.rs2), 32'(dataE.rs2));
        checkValue(name, "rd", 32'(ed.rd), 32'(dataE.rd));
    endtask

    task automatic waitForReset(output logic released);
        integer cycles;
        cycles = 0;
        while (rstN !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        released = (rstN === 1'b1);
    endtask

    // driven on a falling edge and returns on the next one
    task automatic applyCase(input caseT c);
        instrD    = c.instr;
        pcD       = c.pc;
        pcPlus4D  = c.pc + 32'd4;
        stallE    = c.stall;
        flushE    = c.flush;
        writeBack = c.wb;
        @(posedge clk);
        @(negedge clk);
        checkOutputs(c.name, c.expCtrl, c.expData);
    endtask

    initial begin
        logic released;
        errors    = 0;
        checks    = 0;
        seed      = 32'h235bbfc4;
        instrD    = '0;
        pcD       = '0;
        pcPlus4D  = '0;
        writeBack = '0;
        stallE    = 1'b0;
        flushE    = 1'b0;
        buildCases();
        @(posedge clk);
        @(negedge clk);
        checkOutputs("reset", bubbleCtrl, '0);  // still inside reset
        waitForReset(released);
        if (!released) begin
            $display("Timeout: reset was not released within 20 clock cycles");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            @(negedge clk);
            foreach (cases[i]) begin
                applyCase(cases[i]);
            end
            writeBack = '0;
            $display("%0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

//--- list.f
+incdir+src
src/rvDecodePkg.sv
src/aluDecoder.sv
src/controlUnit.sv
src/immExtend.sv
src/regFile.sv
src/decodeStage.sv
verif/decodeStage_tb.sv

//--- Bender.yml
package:
  name: rv_decode_stage

export_include_dirs:
  - src

sources:
  - src/rvDecodePkg.sv
  - src/aluDecoder.sv
  - src/controlUnit.sv
  - src/immExtend.sv
  - src/regFile.sv
  - src/decodeStage.sv
  - target: test
    files:
      - verif/decodeStage_tb.sv
